// ==== rtl/wbq_pkg.sv ====
/*
 * Shared types for the Wishbone block-RAM queue. Holds the word and
 * address types, the register map and the bus and status structs.
 */
`default_nettype none

package wbq_pkg;

    // One queue word, also the width of the Wishbone data bus
    typedef logic [31:0] wbq_data_t;

    // Word address on the Wishbone bus
    typedef logic [3:0] wbq_addr_t;

    // Register map, in words
    // A write to the data register enqueues and a read of it returns zero
    localparam wbq_addr_t REG_DATA   = 4'd0;
    // Status reads back queue_status_t and any write clears overflow
    localparam wbq_addr_t REG_STATUS = 4'd1;
    // Number of words held, read-only
    localparam wbq_addr_t REG_LEVEL  = 4'd2;

    // Master side of a Wishbone classic port
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        wbq_addr_t adr;
        wbq_data_t dat;
    } wb_req_t;

    // Slave side of a Wishbone classic port
    typedef struct packed {
        wbq_data_t dat;
        logic      ack;
    } wb_rsp_t;

    // Low bits of the status register, zero-extended on read
    typedef struct packed {
        logic overflow;
        logic not_empty;
        logic almost_full;
        logic not_full;
    } queue_status_t;

endpackage

`default_nettype wire

// ==== rtl/fifo_ram.sv ====
/*
 * Simple dual-port memory for the queue. One write port and one read
 * port with a registered output, so that it maps onto block RAM.
 */
`default_nettype none

module fifo_ram
#(
    parameter int N_ENTRIES = 16
)
(
    input  logic                           clk,

    input  logic                           wr_en,
    input  logic [$clog2(N_ENTRIES)-1:0]   wr_addr,
    input  wbq_pkg::wbq_data_t             wr_data,

    input  logic                           rd_en,
    input  logic [$clog2(N_ENTRIES)-1:0]   rd_addr,
    output wbq_pkg::wbq_data_t             rd_data
);
    import wbq_pkg::*;

    // One word per slot of the queue
    wbq_data_t mem [N_ENTRIES];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end

        // The output register loads only on a read, as block RAM does
        // The core never reads and writes one address on the same edge,
        // since a read needs data and a write needs a free slot
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fifo_bram_core.sv ====
/*
 * Block-RAM FIFO core. Keeps the pointers and the occupancy count,
 * derives full, empty and almost-full, and reads with one cycle of
 * latency through fifo_ram.
 */
`default_nettype none

module fifo_bram_core
#(
    parameter int N_ENTRIES = 16,
    parameter int THRESHOLD = 4
)
(
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         wr_req,
    input  wbq_pkg::wbq_data_t           data,
    output logic                         full,
    output logic                         almost_full,
    output logic                         empty,

    input  logic                         rd_req,
    output wbq_pkg::wbq_data_t           q,
    output logic [$clog2(N_ENTRIES):0]   used
);
    localparam int PTR_W = $clog2(N_ENTRIES);

    // Pointers wrap naturally because the depth is a power of two
    typedef logic [PTR_W-1:0] ptr_t;
    // The count needs one more bit so that it can reach N_ENTRIES
    typedef logic [PTR_W:0]   count_t;

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;

    logic wr_ok;
    logic rd_ok;

    // Flags come straight from the registered count, so they move on the
    // same edge as the write or read that changed it
    assign full        = (count == count_t'(N_ENTRIES));
    assign empty       = (count == '0);
    assign almost_full = (count >= count_t'(N_ENTRIES - THRESHOLD));
    assign used        = count;

    // Overflow and underflow checking
    // A write while full and a read while empty are both dropped
    assign wr_ok = wr_req && !full;
    assign rd_ok = rd_req && !empty;

    always_ff @(posedge clk)
    begin
        if (wr_ok)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end

        if (rd_ok)
        begin
            rd_ptr <= rd_ptr + 1'b1;
        end

        // A write and a read together leave the count alone
        case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
    end

    // Read data shows up on q in the cycle after rd_req
    fifo_ram
    #(
        .N_ENTRIES (N_ENTRIES)
    )
    u_fifo_ram
    (
        .clk     (clk),
        .wr_en   (wr_ok),
        .wr_addr (wr_ptr),
        .wr_data (data),
        .rd_en   (rd_ok),
        .rd_addr (rd_ptr),
        .rd_data (q)
    );

endmodule

`default_nettype wire

// ==== rtl/fifo_bram.sv ====
/*
 * Show-ahead queue around the block-RAM core. Moves the head word into
 * a register so that it sits on first while not_empty is high.
 */
`default_nettype none

module fifo_bram
#(
    parameter int N_ENTRIES = 16,
    parameter int THRESHOLD = 4
)
(
    input  logic                         clk,
    input  logic                         reset,

    input  wbq_pkg::wbq_data_t           enq_data,
    input  logic                         enq_en,
    output logic                         not_full,
    output logic                         almost_full,

    output wbq_pkg::wbq_data_t           first,
    input  logic                         deq_en,
    output logic                         not_empty,
    output logic [$clog2(N_ENTRIES):0]   level
);
    import wbq_pkg::*;

    typedef logic [$clog2(N_ENTRIES):0] level_t;

    logic      core_full;
    logic      core_empty;
    logic      rd_req;
    // High in the cycle where the core's q holds a word for the head
    logic      rd_pend;
    wbq_data_t core_q;
    level_t    core_used;

    assign not_full = !core_full;

    // Fetch when the head slot is free or being consumed and the RAM has
    // data. Only one word may be in flight, since there is a single slot
    assign rd_req = !core_empty && !rd_pend && (!not_empty || deq_en);

    always_ff @(posedge clk)
    begin
        // Head word loads only when a fetched word arrives
        if (rd_pend)
        begin
            first <= core_q;
        end

        rd_pend   <= rd_req;
        // The head stays valid until dequeued, and refills when q is ready
        not_empty <= rd_pend || (not_empty && !deq_en);

        if (reset)
        begin
            rd_pend   <= 1'b0;
            not_empty <= 1'b0;
        end
    end

    // Words in the RAM plus the one in the head slot
    assign level = core_used + level_t'(not_empty);

    fifo_bram_core
    #(
        .N_ENTRIES (N_ENTRIES),
        .THRESHOLD (THRESHOLD)
    )
    u_fifo_bram_core
    (
        .clk         (clk),
        .reset       (reset),
        .wr_req      (enq_en),
        .data        (enq_data),
        .full        (core_full),
        .almost_full (almost_full),
        .empty       (core_empty),
        .rd_req      (rd_req),
        .q           (core_q),
        .used        (core_used)
    );

endmodule

`default_nettype wire

// ==== rtl/wb_queue_regs.sv ====
/*
 * Wishbone classic register slave for the queue. Data writes enqueue,
 * status and level read back the queue state, and a sticky overflow flag
 * records writes dropped while full.
 */
`default_nettype none

module wb_queue_regs
#(
    parameter int N_ENTRIES = 16
)
(
    input  logic                         clk,
    input  logic                         reset,

    input  wbq_pkg::wb_req_t             wb_req,
    output wbq_pkg::wb_rsp_t             wb_rsp,

    output logic                         enq_en,
    output wbq_pkg::wbq_data_t           enq_data,
    input  logic                         not_full,
    input  logic                         almost_full,
    input  logic                         not_empty,
    input  logic [$clog2(N_ENTRIES):0]   level
);
    import wbq_pkg::*;

    localparam int LVL_W = $clog2(N_ENTRIES) + 1;

    logic          ack;
    logic          overflow;
    // First cycle of a bus access, the one that gets acked on its edge
    logic          access;
    logic          data_wr;
    logic          status_wr;
    wbq_data_t     rd_word;
    wbq_data_t     rd_dat;
    queue_status_t status;

    // Ack is blocked in the cycle after an ack, so it is never two cycles
    // long and a held strobe is not taken twice
    assign access    = wb_req.cyc && wb_req.stb && !ack;
    assign data_wr   = access && wb_req.we && (wb_req.adr == REG_DATA);
    assign status_wr = access && wb_req.we && (wb_req.adr == REG_STATUS);

    // The enqueue lands on the edge that raises ack
    assign enq_en   = data_wr && not_full;
    assign enq_data = wb_req.dat;

    always_comb
    begin
        status.overflow    = overflow;
        status.not_empty   = not_empty;
        status.almost_full = almost_full;
        status.not_full    = not_full;
    end

    // Read mux
    // Data register and unmapped offsets read as zero
    always_comb
    begin
        rd_word = '0;
        case (wb_req.adr)
            REG_STATUS: rd_word[$bits(queue_status_t)-1:0] = status;
            REG_LEVEL:  rd_word[LVL_W-1:0] = level;
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        ack <= access;

        // Read data is captured with ack and holds while ack is high
        if (access)
        begin
            rd_dat <= wb_req.we ? '0 : rd_word;
        end

        // A dropped data write wins over a clear, though both cannot
        // happen in one access since they use different offsets
        if (data_wr && !not_full)
        begin
            overflow <= 1'b1;
        end
        else if (status_wr)
        begin
            overflow <= 1'b0;
        end

        if (reset)
        begin
            ack      <= 1'b0;
            overflow <= 1'b0;
        end
    end

    always_comb
    begin
        wb_rsp.dat = rd_dat;
        wb_rsp.ack = ack;
    end

endmodule

`default_nettype wire

// ==== rtl/wb_queue_top.sv ====
/*
 * Top of the Wishbone block-RAM queue. Joins the register slave to the
 * show-ahead queue and hands the head word to a streaming consumer.
 */
`default_nettype none

module wb_queue_top
#(
    parameter int N_ENTRIES = 16,
    parameter int THRESHOLD = 4
)
(
    input  logic                 clk,
    input  logic                 reset,

    input  wbq_pkg::wb_req_t     wb_req,
    output wbq_pkg::wb_rsp_t     wb_rsp,

    // Consumer side, deq_en only while not_empty is high
    output wbq_pkg::wbq_data_t   first,
    output logic                 not_empty,
    input  logic                 deq_en
);
    import wbq_pkg::*;

    typedef logic [$clog2(N_ENTRIES):0] level_t;

    logic      enq_en;
    wbq_data_t enq_data;
    logic      not_full;
    logic      almost_full;
    level_t    level;

    // Bus side
    wb_queue_regs
    #(
        .N_ENTRIES (N_ENTRIES)
    )
    u_wb_queue_regs
    (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .enq_en      (enq_en),
        .enq_data    (enq_data),
        .not_full    (not_full),
        .almost_full (almost_full),
        .not_empty   (not_empty),
        .level       (level)
    );

    // Queue, with not_empty shared by the consumer and the status register
    fifo_bram
    #(
        .N_ENTRIES (N_ENTRIES),
        .THRESHOLD (THRESHOLD)
    )
    u_fifo_bram
    (
        .clk         (clk),
        .reset       (reset),
        .enq_data    (enq_data),
        .enq_en      (enq_en),
        .not_full    (not_full),
        .almost_full (almost_full),
        .first       (first),
        .deq_en      (deq_en),
        .not_empty   (not_empty),
        .level       (level)
    );

endmodule

`default_nettype wire

// ==== dv/tb_wb_queue.sv ====
/*
 * Directed testbench for the Wishbone block-RAM queue. Drives the bus and
 * the consumer port, keeps a queue model of the expected words and checks
 * head order, status flags, level and the overflow flag.
 */
`default_nettype none

module tb_wb_queue;
    timeunit 1ns;
    timeprecision 1ns;

    import wbq_pkg::*;

    localparam int N_ENTRIES = 16;
    localparam int THRESHOLD = 4;
    // A full RAM plus the head register
    localparam int CAPACITY = N_ENTRIES + 1;
    // About 400 cycles of tests, with a wide margin
    localparam int TIMEOUT_CYCLES = 3000;

    logic        clk;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    wbq_data_t   first;
    logic        not_empty;
    logic        deq_en;
    int          cycles = 0;

    // Expected words, oldest at index 0
    wbq_data_t model[$];

    wb_queue_top
    #(
        .N_ENTRIES (N_ENTRIES),
        .THRESHOLD (THRESHOLD)
    )
    u_wb_queue_top
    (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .first     (first),
        .not_empty (not_empty),
        .deq_en    (deq_en)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    // Watchdog so that a missing ack or a stuck queue cannot hang the run
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            abort_run($sformatf("Timeout, tests did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic check_eq(input string name, input wbq_data_t got, input wbq_data_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run("Stopped at the first mismatch");
        end
    endtask

    // Status once the queue has settled
    // The head register holds one word and the rest sit in the RAM,
    // where the flags are taken
    function automatic wbq_data_t exp_status(input int count, input logic ovf);
        int            ram_words;
        queue_status_t st;
        ram_words      = (count > 0) ? count - 1 : 0;
        st.overflow    = ovf;
        st.not_empty   = (count > 0);
        st.almost_full = (ram_words >= N_ENTRIES - THRESHOLD);
        st.not_full    = (ram_words < N_ENTRIES);
        return {28'h0, st};
    endfunction

    // One Wishbone classic cycle, held until ack and dropped on the next edge
    task automatic bus_access(input logic we, input wbq_addr_t adr, input wbq_data_t wdat,
                              output wbq_data_t rdat);
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= wdat;
        @(negedge clk);
        while (!wb_rsp.ack)
        begin
            @(negedge clk);
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input wbq_addr_t adr, input wbq_data_t dat);
        wbq_data_t unused_rd;
        bus_access(1'b1, adr, dat, unused_rd);
    endtask

    task automatic wb_read(input wbq_addr_t adr, output wbq_data_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    // Waits for a head word, checks it against the model and pops it
    task automatic consume();
        wbq_data_t exp;
        @(negedge clk);
        while (!not_empty)
        begin
            @(negedge clk);
        end
        if (model.size() == 0)
        begin
            abort_run("The queue shows a head word that was never written");
        end
        exp = model.pop_front();
        check_eq("first", first, exp);
        @(posedge clk);
        deq_en <= 1'b1;
        @(posedge clk);
        deq_en <= 1'b0;
    endtask

    // Enqueue to visible takes two edges after the ack edge
    task automatic expect_visible(input int limit);
        logic seen;
        seen = 1'b0;
        repeat (limit)
        begin
            @(negedge clk);
            seen = seen | not_empty;
        end
        if (!seen)
        begin
            abort_run($sformatf("not_empty did not rise within %0d cycles of the ack", limit));
        end
    endtask

    task automatic read_reset_state();
        wbq_data_t rd;
        wb_read(REG_STATUS, rd);
        check_eq("status", rd, exp_status(0, 1'b0));
        wb_read(REG_LEVEL, rd);
        check_eq("level", rd, 32'd0);
        @(negedge clk);
        check_eq("not_empty", {31'b0, not_empty}, 32'd0);
    endtask

    task automatic order_words();
        wbq_data_t word;
        wbq_data_t rd;
        int        i;
        for (i = 0; i < 8; i++)
        begin
            word = $urandom();
            wb_write(REG_DATA, word);
            model.push_back(word);
            if (i == 0)
            begin
                expect_visible(2);
            end
        end
        // Idle gaps between dequeues exercise the refill path
        while (model.size() > 0)
        begin
            repeat ($urandom_range(0, 3)) @(posedge clk);
            consume();
        end
        wb_read(REG_LEVEL, rd);
        check_eq("level", rd, 32'd0);
    endtask

    task automatic fill_to_full();
        wbq_data_t word;
        wbq_data_t rd;
        while (model.size() < CAPACITY)
        begin
            word = $urandom();
            wb_write(REG_DATA, word);
            model.push_back(word);
            repeat (2) @(posedge clk);
            wb_read(REG_STATUS, rd);
            check_eq("status", rd, exp_status(model.size(), 1'b0));
            wb_read(REG_LEVEL, rd);
            check_eq("level", rd, wbq_data_t'(model.size()));
        end
    endtask

    task automatic overflow_and_drain();
        wbq_data_t rd;
        // This write is acked but dropped, so the model does not take it
        wb_write(REG_DATA, $urandom());
        repeat (2) @(posedge clk);
        wb_read(REG_LEVEL, rd);
        check_eq("level", rd, wbq_data_t'(CAPACITY));
        wb_read(REG_STATUS, rd);
        check_eq("status", rd, exp_status(CAPACITY, 1'b1));
        wb_write(REG_STATUS, 32'h0);
        wb_read(REG_STATUS, rd);
        check_eq("status", rd, exp_status(CAPACITY, 1'b0));
        while (model.size() > 0)
        begin
            consume();
        end
        // The dropped word must not turn up after the accepted ones
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_eq("not_empty", {31'b0, not_empty}, 32'd0);
    endtask

    task automatic stream_concurrently();
        wbq_data_t rd;
        fork
            begin
                wbq_data_t word;
                int        i;
                for (i = 0; i < 30; i++)
                begin
                    // Stay clear of full so that no write is dropped
                    while (model.size() >= 14)
                    begin
                        @(posedge clk);
                    end
                    word = $urandom();
                    wb_write(REG_DATA, word);
                    model.push_back(word);
                end
            end
            begin
                int j;
                for (j = 0; j < 26; j++)
                begin
                    repeat ($urandom_range(0, 3)) @(posedge clk);
                    consume();
                end
            end
        join
        repeat (2) @(posedge clk);
        wb_read(REG_LEVEL, rd);
        check_eq("level", rd, wbq_data_t'(model.size()));
    endtask

    initial
    begin
        void'($urandom(32'h7146));
        wb_req <= '0;
        deq_en <= 1'b0;
        reset  <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        read_reset_state();
        order_words();
        fill_to_full();
        overflow_and_drain();
        stream_concurrently();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/wbq_pkg.sv
rtl/fifo_ram.sv
rtl/fifo_bram_core.sv
rtl/fifo_bram.sv
rtl/wb_queue_regs.sv
rtl/wb_queue_top.sv
dv/tb_wb_queue.sv

// ==== run.sh ====
#!/bin/sh
# Build the queue testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_wb_queue -f sim.f -o tb_wb_queue \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_wb_queue > sim.log 2>&1 || echo "Simulation exited with an error"
cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
